// File: src.f
+incdir+hdl
hdl/acsi_pkg.sv
hdl/acsi_bus_if.sv
hdl/acsi_io_if.sv
hdl/dma_regs.sv
hdl/acsi_cmd.sv
hdl/io_status_port.sv
hdl/acsi_top.sv
dv/acsi_properties.sv
dv/acsi_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= acsi_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/acsi_tb.sv
/*
 * ACSI command path testbench
 * directed tests for command collection, IO readout,
 * ack/nak completion, disabled targets and the sector count path
 */
`timescale 1ns/10ps
`include "acsi_defines.svh"

module acsi_tb import acsi_pkg::*; ();

    localparam int   clk_period = 40;
    localparam int   num_tests  = 5;
    localparam logic reg_data   = 1'b0;
    localparam logic reg_mode   = 1'b1;

    logic                         clk;
    logic                         reset;
    logic                         cpu_sel;
    logic                         cpu_rw;
    logic                         cpu_reg;
    acsi_byte_t                   cpu_din;
    acsi_byte_t                   cpu_dout;
    logic                         irq;
    logic                         io_rd;
    logic [2:0]                   io_index;
    acsi_byte_t                   io_data;
    logic                         io_valid;
    logic                         io_ack;
    logic                         io_nak;
    acsi_byte_t                   io_status;
    logic [`ACSI_NUM_TARGETS-1:0] enable;

    // expected copy of the last command and the last acked status
    acsi_byte_t   exp_cmd;
    acsi_opcode_e exp_op;
    acsi_byte_t   exp_parms [`ACSI_NUM_PARMS];
    acsi_byte_t   exp_status;

    int          error_count;
    int          check_count;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    int unsigned seed;

    acsi_top acsi_top_i (
        .clk       (clk),
        .reset     (reset),
        .cpu_sel   (cpu_sel),
        .cpu_rw    (cpu_rw),
        .cpu_reg   (cpu_reg),
        .cpu_din   (cpu_din),
        .cpu_dout  (cpu_dout),
        .irq       (irq),
        .io_rd     (io_rd),
        .io_index  (io_index),
        .io_data   (io_data),
        .io_valid  (io_valid),
        .io_ack    (io_ack),
        .io_nak    (io_nak),
        .io_status (io_status),
        .enable    (enable)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // watchdog, 200 cycles per test
    initial begin
        repeat (num_tests * 200) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", num_tests * 200);
        $display("TB FAILED");
        $finish;
    end

    task automatic check_byte(input string name, input acsi_byte_t got, input acsi_byte_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_opcode(input string name, input acsi_opcode_e got,
                                input acsi_opcode_e exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // one-cycle CPU write strobe, results visible after the capturing edge
    task automatic cpu_write(input logic which, input acsi_byte_t data);
        @(posedge clk);
        #5;
        cpu_sel = 1'b1;
        cpu_rw  = 1'b0;
        cpu_reg = which;
        cpu_din = data;
        @(posedge clk);
        #5;
        cpu_sel = 1'b0;
    endtask

    // read data is combinational, sampled mid-cycle
    task automatic cpu_read(input logic which, output acsi_byte_t data);
        @(posedge clk);
        #5;
        cpu_sel = 1'b1;
        cpu_rw  = 1'b1;
        cpu_reg = which;
        #10;
        data = cpu_dout;
        @(posedge clk);
        #5;
        cpu_sel = 1'b0;
        cpu_rw  = 1'b0;
    endtask

    // io_valid is due exactly one cycle after io_rd
    task automatic io_read(input logic [2:0] index, output acsi_byte_t data);
        @(posedge clk);
        #5;
        io_rd    = 1'b1;
        io_index = index;
        @(posedge clk);
        #5;
        io_rd = 1'b0;
        check_bit("io_valid", io_valid, 1'b1);
        data = io_data;
        @(posedge clk);
        #5;
        check_bit("io_valid", io_valid, 1'b0);
    endtask

    // ack or nak strobe from the IO controller
    task automatic io_finish(input logic ack, input acsi_byte_t status);
        @(posedge clk);
        #5;
        io_ack    = ack;
        io_nak    = !ack;
        io_status = status;
        @(posedge clk);
        #5;
        io_ack = 1'b0;
        io_nak = 1'b0;
    endtask

    // first byte plus all parameters, irq checked after each byte
    task automatic send_command(input acsi_target_t tgt, input acsi_opcode_e op,
                                input logic enabled);
        acsi_byte_t rd;
        logic       exp_irq;
        cpu_write(reg_mode, 8'h00);
        exp_op  = op;
        exp_cmd = {tgt, op};
        cpu_write(reg_data, exp_cmd);
        check_bit("irq", irq, enabled);
        if (enabled) begin
            // status read acknowledges the interrupt
            cpu_read(reg_data, rd);
            check_byte("cpu_dout", rd, exp_status);
            check_bit("irq", irq, 1'b0);
        end
        cpu_write(reg_mode, 8'(1 << `ACSI_MODE_A1_BIT));
        for (int i = 0; i < `ACSI_NUM_PARMS; i++) begin
            exp_parms[i] = 8'($urandom);
            cpu_write(reg_data, exp_parms[i]);
            // the last parameter hands over to the IO side silently
            exp_irq = enabled && (i < `ACSI_NUM_PARMS - 1);
            check_bit("irq", irq, exp_irq);
            if (exp_irq) begin
                cpu_read(reg_data, rd);
                check_byte("cpu_dout", rd, exp_status);
                check_bit("irq", irq, 1'b0);
            end
        end
        io_read(3'(`ACSI_IDX_BUSY), rd);
        check_byte("busy", rd, {7'b0000000, enabled});
    endtask

    // IO side readback of the stored command bytes
    task automatic check_readback();
        acsi_byte_t rd;
        io_read(3'(`ACSI_IDX_CMD), rd);
        check_byte("io_data[0]", rd, exp_cmd);
        check_opcode("opcode", acsi_opcode_e'(rd[4:0]), exp_op);
        for (int i = 0; i < `ACSI_NUM_PARMS; i++) begin
            io_read(3'(`ACSI_IDX_PARM0 + i), rd);
            check_byte($sformatf("io_data[%0d]", `ACSI_IDX_PARM0 + i), rd, exp_parms[i]);
        end
    endtask

    task automatic test_full_command();
        enable = '1;
        send_command(3'd2, read_sector, 1'b1);
    endtask

    task automatic test_readback();
        check_readback();
    endtask

    task automatic test_ack_nak();
        acsi_byte_t st;
        acsi_byte_t rd;
        st = 8'($urandom);
        io_finish(1'b1, st);
        exp_status = st;
        check_bit("irq", irq, 1'b1);
        io_read(3'(`ACSI_IDX_BUSY), rd);
        check_byte("busy", rd, 8'h00);
        cpu_read(reg_data, rd);
        check_byte("cpu_dout", rd, exp_status);
        check_bit("irq", irq, 1'b0);
        // nak leaves status and irq alone
        send_command(3'd5, write_sector, 1'b1);
        io_finish(1'b0, 8'($urandom));
        check_bit("irq", irq, 1'b0);
        io_read(3'(`ACSI_IDX_BUSY), rd);
        check_byte("busy", rd, 8'h00);
        cpu_read(reg_data, rd);
        check_byte("cpu_dout", rd, exp_status);
    endtask

    task automatic test_disabled_target();
        enable    = '1;
        enable[6] = 1'b0;
        send_command(3'd6, mode_sense, 1'b0);
        check_readback();
        enable = '1;
    endtask

    task automatic test_sector_count();
        acsi_byte_t mode;
        acsi_byte_t sc;
        acsi_byte_t rd;
        mode = 8'(1 << `ACSI_MODE_SC_BIT);
        sc   = 8'($urandom);
        cpu_write(reg_mode, mode);
        cpu_write(reg_data, sc);
        check_bit("irq", irq, 1'b0);
        io_read(3'(`ACSI_IDX_SECCNT), rd);
        check_byte("io_data[7]", rd, sc);
        cpu_read(reg_data, rd);
        check_byte("cpu_dout", rd, sc);
        cpu_read(reg_mode, rd);
        check_byte("mode", rd, mode);
        check_bit("irq", irq, 1'b0);
        // command bytes from the previous test stay put
        check_readback();
        cpu_write(reg_mode, 8'h00);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (error_count != errors_at_start) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errors_at_start);
        end else begin
            $display("test %s: ok", name);
        end
        errors_at_start = error_count;
    endtask

    initial begin
        seed            = $urandom(35);
        reset           = 1'b1;
        cpu_sel         = 1'b0;
        cpu_rw          = 1'b0;
        cpu_reg         = 1'b0;
        cpu_din         = '0;
        io_rd           = 1'b0;
        io_index        = '0;
        io_ack          = 1'b0;
        io_nak          = 1'b0;
        io_status       = '0;
        enable          = '1;
        exp_status      = '0;
        error_count     = 0;
        check_count     = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;
        test_full_command();
        report_test("full command");
        test_readback();
        report_test("io readback");
        test_ack_nak();
        report_test("ack and nak");
        test_disabled_target();
        report_test("disabled target");
        test_sector_count();
        report_test("sector count");
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: dv/acsi_properties.sv
/*
 * ACSI command path assertions
 * IO readout timing, irq reset value and nak behavior,
 * bound to the top level
 */
`timescale 1ns/10ps

module acsi_properties (
    input logic clk,
    input logic reset,
    input logic cpu_sel,
    input logic cpu_rw,
    input logic io_rd,
    input logic io_valid,
    input logic io_ack,
    input logic io_nak,
    input logic irq
);

    // every read is answered one cycle later
    io_valid_follows_rd: assert property (@(posedge clk) disable iff (reset)
        io_rd |=> io_valid)
        else $error("io_valid missing one cycle after io_rd");

    // no answer without a read
    io_valid_only_after_rd: assert property (@(posedge clk)
        (!io_rd && !reset) |=> !io_valid)
        else $error("io_valid without a preceding io_rd");

    // interrupt cleared by reset
    irq_low_after_reset: assert property (@(posedge clk)
        reset |=> !irq)
        else $error("irq high in the cycle after reset");

    // a CPU write or an ack in the same cycle may still raise irq
    nak_keeps_irq_low: assert property (@(posedge clk) disable iff (reset)
        (io_nak && !io_ack && !irq && !(cpu_sel && !cpu_rw)) |=> !irq)
        else $error("irq raised by a nak");

endmodule

bind acsi_top acsi_properties props_i (
    .clk      (clk),
    .reset    (reset),
    .cpu_sel  (cpu_sel),
    .cpu_rw   (cpu_rw),
    .io_rd    (io_rd),
    .io_valid (io_valid),
    .io_ack   (io_ack),
    .io_nak   (io_nak),
    .irq      (irq)
);

// File: hdl/acsi_top.sv
/*
 * ACSI hard disk command path
 * DMA registers, command collector and IO controller port
 * connected to plain CPU and IO ports
 */
`timescale 1ns/10ps
`include "acsi_defines.svh"

module acsi_top import acsi_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    // CPU side
    input  logic                          cpu_sel,
    input  logic                          cpu_rw,
    input  logic                          cpu_reg,
    input  acsi_byte_t                    cpu_din,
    output acsi_byte_t                    cpu_dout,
    output logic                          irq,
    // IO controller side
    input  logic                          io_rd,
    input  logic [2:0]                    io_index,
    output acsi_byte_t                    io_data,
    output logic                          io_valid,
    input  logic                          io_ack,
    input  logic                          io_nak,
    input  acsi_byte_t                    io_status,
    // target enables
    input  logic [`ACSI_NUM_TARGETS-1:0]  enable
);

    acsi_byte_t sector_count;

    acsi_bus_if bus_if ();
    acsi_io_if  io_if ();

    dma_regs dma_regs_i (
        .clk          (clk),
        .reset        (reset),
        .cpu_sel      (cpu_sel),
        .cpu_rw       (cpu_rw),
        .cpu_reg      (cpu_reg),
        .cpu_din      (cpu_din),
        .cpu_dout     (cpu_dout),
        .bus          (bus_if.master),
        .sector_count (sector_count)
    );

    acsi_cmd acsi_cmd_i (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .bus    (bus_if.slave),
        .io     (io_if.collector),
        .irq    (irq)
    );

    io_status_port io_status_port_i (
        .clk          (clk),
        .reset        (reset),
        .io_rd        (io_rd),
        .io_index     (io_index),
        .io_data      (io_data),
        .io_valid     (io_valid),
        .io_ack       (io_ack),
        .io_nak       (io_nak),
        .io_status    (io_status),
        .sector_count (sector_count),
        .io           (io_if.port)
    );

endmodule

// File: hdl/io_status_port.sv
/*
 * IO controller port
 * registered readout of the captured command and sector count,
 * ack/nak strobes and the held status byte
 */
`timescale 1ns/10ps
`include "acsi_defines.svh"

module io_status_port import acsi_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // readout request
    input  logic       io_rd,
    input  logic [2:0] io_index,
    output acsi_byte_t io_data,
    output logic       io_valid,
    // command completion
    input  logic       io_ack,
    input  logic       io_nak,
    input  acsi_byte_t io_status,
    // from the DMA register block
    input  acsi_byte_t sector_count,
    acsi_io_if.port    io
);

    acsi_byte_t status_q;

    // index steers the collector mux directly
    assign io.status_sel = io_index;

    // strobes go straight through so the collector reacts next cycle
    assign io.dma_ack = io_ack;
    assign io.dma_nak = io_nak;

    // status held until the next ack
    always_ff @(posedge clk) begin
        if (reset) begin
            status_q <= '0;
        end else if (io_ack) begin
            status_q <= io_status;
        end
    end

    assign io.dma_status = status_q;

    // one-cycle valid pulse for each read
    always_ff @(posedge clk) begin
        if (reset) begin
            io_valid <= 1'b0;
        end else begin
            io_valid <= io_rd;
        end
    end

    // sector count lives outside the collector
    always_ff @(posedge clk) begin
        if (io_rd) begin
            if (io_index == 3'(`ACSI_IDX_SECCNT)) begin
                io_data <= sector_count;
            end else begin
                io_data <= io.status_byte;
            end
        end
    end

endmodule

// File: hdl/acsi_cmd.sv
/*
 * ACSI command collector
 * captures target, opcode and parameter bytes written by the CPU,
 * acknowledges each byte by interrupt and requests IO service
 */
`timescale 1ns/10ps
`include "acsi_defines.svh"

module acsi_cmd import acsi_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`ACSI_NUM_TARGETS-1:0]  enable,
    acsi_bus_if.slave                     bus,
    acsi_io_if.collector                  io,
    output logic                          irq
);

    localparam logic [2:0] num_parms = 3'(`ACSI_NUM_PARMS);
    // the last parameter hands over to the IO controller
    localparam logic [2:0] last_parm = 3'(`ACSI_NUM_PARMS - 1);

    acsi_state_e  state;
    acsi_target_t target;
    acsi_opcode_e opcode;
    logic [2:0]   byte_counter;
    acsi_byte_t   parms [`ACSI_NUM_PARMS];

    logic       cpu_wr;
    logic       cpu_rd;
    logic       parm_wr;
    logic       busy;
    logic [2:0] parm_sel;

    assign cpu_wr  = bus.sel && !bus.rw;
    assign cpu_rd  = bus.sel && bus.rw;
    // bytes past the last parameter are dropped
    assign parm_wr = cpu_wr && bus.a1 && (byte_counter < num_parms);
    assign busy    = (state == wait_io);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idle;
            irq          <= 1'b0;
            target       <= '0;
            opcode       <= test_unit_ready;
            byte_counter <= '0;
        end else begin
            // IO controller accepted the command
            if (io.dma_ack && busy) begin
                irq   <= 1'b1;
                state <= idle;
            end
            // no such device, back to idle silently
            if (io.dma_nak && busy) begin
                state <= idle;
            end
            // status read acknowledges the interrupt
            if (cpu_rd) begin
                irq <= 1'b0;
            end
            // CPU writes last so they win over the IO side
            if (cpu_wr && !bus.a1) begin
                // first command byte, target in the top bits
                target       <= bus.din[7:5];
                opcode       <= acsi_opcode_e'(bus.din[4:0]);
                byte_counter <= '0;
                if (enable[bus.din[7:5]]) begin
                    irq   <= 1'b1;
                    state <= collect;
                end else begin
                    state <= idle;
                end
            end else if (parm_wr) begin
                byte_counter <= byte_counter + 3'd1;
                if (enable[target]) begin
                    // auto-ack all but the last parameter
                    if (byte_counter < last_parm) begin
                        irq <= 1'b1;
                    end else begin
                        state <= wait_io;
                    end
                end
            end
        end
    end

    // parameter storage
    always_ff @(posedge clk) begin
        if (parm_wr) begin
            parms[byte_counter] <= bus.din;
        end
    end

    // CPU always reads the last acked status
    assign bus.dout = io.dma_status;

    // readout for the IO controller
    assign parm_sel = io.status_sel - 3'(`ACSI_IDX_PARM0);

    always_comb begin
        if (io.status_sel == 3'(`ACSI_IDX_CMD)) begin
            io.status_byte = {target, opcode};
        end else if (io.status_sel == 3'(`ACSI_IDX_BUSY)) begin
            io.status_byte = {7'b0000000, busy};
        end else if (parm_sel < num_parms) begin
            io.status_byte = parms[parm_sel];
        end else begin
            io.status_byte = 8'h00;
        end
    end

endmodule

// File: hdl/dma_regs.sv
/*
 * DMA chip register block
 * holds the mode and sector count registers and routes data
 * register accesses to the sector count or to the ACSI bus
 */
`timescale 1ns/10ps
`include "acsi_defines.svh"

module dma_regs import acsi_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // CPU register access
    input  logic       cpu_sel,
    input  logic       cpu_rw,
    input  logic       cpu_reg,
    input  acsi_byte_t cpu_din,
    output acsi_byte_t cpu_dout,
    // forwarded accesses to the command collector
    acsi_bus_if.master bus,
    output acsi_byte_t sector_count
);

    acsi_byte_t mode;
    acsi_byte_t seccnt;

    // decoded accesses
    logic mode_wr;
    logic data_acc;
    logic seccnt_wr;
    logic sc_mode;

    // sector count bit set steers the data register away from ACSI
    assign sc_mode = mode[`ACSI_MODE_SC_BIT];

    // cpu_reg 0 is the data register, 1 the mode register
    assign mode_wr   = cpu_sel && !cpu_rw && cpu_reg;
    assign data_acc  = cpu_sel && !cpu_reg;
    assign seccnt_wr = data_acc && !cpu_rw && sc_mode;

    // mode and sector count registers
    always_ff @(posedge clk) begin
        if (reset) begin
            mode   <= '0;
            seccnt <= '0;
        end else begin
            if (mode_wr) begin
                mode <= cpu_din;
            end
            // sector count only reachable through the data register
            if (seccnt_wr) begin
                seccnt <= cpu_din;
            end
        end
    end

    assign sector_count = seccnt;

    // data register strobe reaches the collector only in ACSI mode
    assign bus.sel = data_acc && !sc_mode;
    assign bus.rw  = cpu_rw;
    assign bus.a1  = mode[`ACSI_MODE_A1_BIT];
    assign bus.din = cpu_din;

    // CPU read data, same cycle as the strobe
    always_comb begin
        if (cpu_reg) begin
            cpu_dout = mode;
        end else if (sc_mode) begin
            cpu_dout = seccnt;
        end else begin
            // ACSI status from the collector
            cpu_dout = bus.dout;
        end
    end

endmodule

// File: hdl/acsi_io_if.sv
/*
 * ACSI IO controller link
 * command byte readout and ack/nak status return between the
 * command collector and the IO controller port
 */
`timescale 1ns/10ps

interface acsi_io_if import acsi_pkg::*; ();

    // readout index into the captured command
    logic [2:0] status_sel;
    // captured byte selected by status_sel
    acsi_byte_t status_byte;
    // one-cycle strobes from the IO controller
    logic       dma_ack;
    logic       dma_nak;
    // last status byte that came with an ack
    acsi_byte_t dma_status;

    // command collector side
    modport collector (input status_sel, dma_ack, dma_nak, dma_status, output status_byte);

    // IO controller port side
    modport port (output status_sel, dma_ack, dma_nak, dma_status, input status_byte);

endinterface

// File: hdl/acsi_bus_if.sv
/*
 * ACSI register bus
 * CPU data register accesses forwarded from the DMA register
 * block to the command collector
 */
`timescale 1ns/10ps

interface acsi_bus_if import acsi_pkg::*; ();

    // single-cycle access strobe
    logic       sel;
    // 1 = read, 0 = write
    logic       rw;
    // ACSI A1 line, clear marks the first command byte
    logic       a1;
    // write data from the CPU
    acsi_byte_t din;
    // status returned on a CPU read
    acsi_byte_t dout;

    // DMA register side
    modport master (output sel, rw, a1, din, input dout);

    // command collector side
    modport slave (input sel, rw, a1, din, output dout);

endinterface

// File: hdl/acsi_pkg.sv
/*
 * ACSI command path types
 * bus byte, target number, group-0 opcodes and collector states
 */
package acsi_pkg;

    // one byte on the CPU or IO bus
    typedef logic [7:0] acsi_byte_t;

    // ACSI target number, upper three bits of the first command byte
    typedef logic [2:0] acsi_target_t;

    // group-0 opcodes, lower five bits of the first command byte
    // codes not listed here are carried by cast
    typedef enum logic [4:0] {
        test_unit_ready = 5'h00,
        request_sense   = 5'h03,
        format_unit     = 5'h04,
        read_sector     = 5'h08,
        write_sector    = 5'h0a,
        seek            = 5'h0b,
        mode_select     = 5'h15,
        mode_sense      = 5'h1a
    } acsi_opcode_e;

    // command collector state
    typedef enum logic [1:0] {
        idle,
        collect,
        wait_io
    } acsi_state_e;

endpackage

// File: hdl/acsi_defines.svh
/*
 * ACSI command path sizes and encodings
 * fixed by the Atari ST DMA chip and the ACSI protocol
 */
`ifndef ACSI_DEFINES_SVH
`define ACSI_DEFINES_SVH

// parameter bytes following the first command byte
`define ACSI_NUM_PARMS      5
// one enable bit per ACSI target
`define ACSI_NUM_TARGETS    8

// mode register bits
`define ACSI_MODE_A1_BIT    1
`define ACSI_MODE_SC_BIT    4

// IO controller readout indexes
`define ACSI_IDX_CMD        0
`define ACSI_IDX_PARM0      1
`define ACSI_IDX_BUSY       6
`define ACSI_IDX_SECCNT     7

`endif
